//--- verilog.f
verilog/vram_pkg.sv
verilog/vram_dpram.sv
verilog/vram_host_port.sv
verilog/vram_scanout.sv
verilog/vram_top.sv
tests/vram_clkgen.sv
tests/vram_assert.sv
tests/vram_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vram_tb \
   -f verilog.f -o vram_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/vram_sim > sim.log 2>&1
status=$?

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status, see sim.log"
   exit 1
fi

echo "simulation passed"
exit 0

//--- tests/vram_tb.sv
// video memory testbench
// host table and random traffic against a word model, then pixel stream checks
`timescale 1ns/1ps
`default_nettype none

module vram_tb
   import vram_pkg::*;
();

   localparam int frame_pixels = vram_words * vram_data_w;
   localparam int line_pixels  = words_per_line * vram_data_w;
   localparam int wait_limit   = 200;  // cycles per handshake
   localparam int num_steps    = 14;
   localparam int num_random   = 3000;

   typedef struct packed
   {
      host_op_t               op;
      logic [vram_addr_w-1:0] addr;
      logic [vram_data_w-1:0] data;
      logic [vram_data_w-1:0] exp_data;
   } host_step_t;

   logic                   clk_a;
   logic                   reset;
   logic                   req_valid;
   host_op_t               req_op;
   logic [vram_addr_w-1:0] req_addr;
   logic [vram_data_w-1:0] req_wdata;
   logic                   req_ready;
   logic                   resp_valid;
   logic [vram_data_w-1:0] resp_data;
   logic                   resp_ready;
   logic                   scan_enable;
   logic                   pix_valid;
   logic                   pix_data;
   logic                   pix_line_start;
   logic                   pix_frame_start;
   logic                   pix_ready;

   host_step_t             steps [0:num_steps-1];
   logic [vram_data_w-1:0] model [0:vram_words-1];  // expected RAM contents
   int                     error_count;
   int                     req_count;
   int                     resp_count = 0;  // transfers seen on the response bus

   vram_clkgen clkgen_i
   (
      .clk_a (clk_a),
      .reset (reset)
   );

   vram_top dut_i
   (
      .clk_a           (clk_a),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_op          (req_op),
      .req_addr        (req_addr),
      .req_wdata       (req_wdata),
      .req_ready       (req_ready),
      .resp_valid      (resp_valid),
      .resp_data       (resp_data),
      .resp_ready      (resp_ready),
      .scan_enable     (scan_enable),
      .pix_valid       (pix_valid),
      .pix_data        (pix_data),
      .pix_line_start  (pix_line_start),
      .pix_frame_start (pix_frame_start),
      .pix_ready       (pix_ready)
   );

   bind vram_top vram_assert assert_i
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .req_ready   (req_ready),
      .resp_valid  (resp_valid),
      .resp_data   (resp_data),
      .resp_ready  (resp_ready),
      .scan_enable (scan_enable),
      .pix_valid   (pix_valid),
      .pix_data    (pix_data),
      .pix_ready   (pix_ready)
   );

   // every response handshake, extra ones included
   always @(posedge clk_a)
   begin
      if (!reset && resp_valid && resp_ready)
         resp_count++;
   end

   task automatic report_failure(input string msg);
      error_count++;
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [vram_data_w-1:0] exp_word,
                             input logic [vram_data_w-1:0] act_word);
      if (act_word !== exp_word)
         report_failure($sformatf("[ERROR] %s expected %h actual %h",
                                  name, exp_word, act_word));
   endtask

   // data, line start and frame start compared together
   task automatic check_pixel(input string name, input int idx, input logic exp_d,
                              input logic exp_ls, input logic exp_fs, input logic act_d,
                              input logic act_ls, input logic act_fs);
      if ({act_d, act_ls, act_fs} !== {exp_d, exp_ls, exp_fs})
         report_failure($sformatf("[ERROR] %s pixel %0d expected %b%b%b actual %b%b%b",
                                  name, idx, exp_d, exp_ls, exp_fs, act_d, act_ls, act_fs));
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic host_access(input host_op_t op, input logic [vram_addr_w-1:0] addr,
                              input logic [vram_data_w-1:0] data, input bit stall,
                              output logic [vram_data_w-1:0] resp);
      int cycles;
      bit taken;
      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = data;
      cycles    = 0;
      while (!req_ready)
      begin
         @(negedge clk_a);
         cycles++;
         if (cycles > wait_limit)
            report_failure("host request was never accepted");
      end
      @(negedge clk_a);  // taken on the edge just passed
      req_valid = 1'b0;
      req_count++;
      cycles = 0;
      taken  = 1'b0;
      while (!taken)
      begin
         resp_ready = stall ? (($urandom % 3) != 0) : 1'b1;
         if (resp_valid && resp_ready)
         begin
            resp  = resp_data;
            taken = 1'b1;
         end
         @(negedge clk_a);
         cycles++;
         if (!taken && cycles > wait_limit)
            report_failure("no response from the host port");
      end
      resp_ready = 1'b0;
   endtask

   task automatic receive_pixel(input bit stall, output logic d, output logic ls,
                                output logic fs);
      int cycles;
      bit taken;
      cycles = 0;
      taken  = 1'b0;
      while (!taken)
      begin
         pix_ready = stall ? (($urandom % 4) != 0) : 1'b1;
         if (pix_valid && pix_ready)
         begin
            d     = pix_data;
            ls    = pix_line_start;
            fs    = pix_frame_start;
            taken = 1'b1;
         end
         @(negedge clk_a);
         cycles++;
         if (!taken && cycles > wait_limit)
            report_failure("pixel stream stopped");
      end
   endtask

   task automatic check_frame(input string name, input bit stall);
      logic d;
      logic ls;
      logic fs;
      logic exp_d;
      for (int p = 0; p < frame_pixels; p++)
      begin
         receive_pixel(stall, d, ls, fs);
         exp_d = model[p / vram_data_w][p % vram_data_w];  // lsb first
         check_pixel(name, p, exp_d, (p % line_pixels) == 0, p == 0, d, ls, fs);
      end
   endtask

   initial
   begin
      logic [vram_data_w-1:0] resp;
      logic [vram_data_w-1:0] exp_data;
      logic [vram_data_w-1:0] data;
      logic [vram_addr_w-1:0] addr;
      host_op_t               op;
      int                     cycles;

      void'($urandom(32'h1b1b_8a20));
      req_valid   = 1'b0;
      req_op      = op_read;
      req_addr    = '0;
      req_wdata   = '0;
      resp_ready  = 1'b0;
      scan_enable = 1'b0;
      pix_ready   = 1'b0;
      error_count = 0;
      req_count   = 0;
      for (int i = 0; i < vram_words; i++)
         model[i] = '0;

      // op, address, data, expected response
      steps = '{
         '{op_read,  15'd0,     32'h0000_0000, 32'h0000_0000},
         '{op_read,  15'd21503, 32'h0000_0000, 32'h0000_0000},
         '{op_write, 15'd0,     32'hdead_beef, 32'hdead_beef},
         '{op_read,  15'd0,     32'h0000_0000, 32'hdead_beef},
         '{op_write, 15'd21503, 32'h8000_0001, 32'h8000_0001},
         '{op_read,  15'd21503, 32'h0000_0000, 32'h8000_0001},
         '{op_write, 15'd100,   32'h1234_5678, 32'h1234_5678},
         '{op_write, 15'd100,   32'hcafe_f00d, 32'hcafe_f00d},
         '{op_write, 15'd100,   32'h0f0f_0f0f, 32'h0f0f_0f0f},
         '{op_read,  15'd100,   32'h0000_0000, 32'h0f0f_0f0f},
         '{op_read,  15'd101,   32'h0000_0000, 32'h0000_0000},
         '{op_write, 15'd23,    32'hffff_ffff, 32'hffff_ffff},
         '{op_read,  15'd23,    32'h0000_0000, 32'hffff_ffff},
         '{op_write, 15'd24,    32'h0000_0001, 32'h0000_0001}
      };

      cycles = 0;
      while (reset !== 1'b0)
      begin
         @(negedge clk_a);
         cycles++;
         if (cycles > wait_limit)
            report_failure("reset was never released");
      end
      @(negedge clk_a);
      if (resp_valid !== 1'b0 || pix_valid !== 1'b0)
         report_failure("outputs not idle after reset");

      for (int i = 0; i < num_steps; i++)
      begin
         host_access(steps[i].op, steps[i].addr, steps[i].data, 1'b0, resp);
         if (steps[i].op == op_write)
            model[steps[i].addr] = steps[i].data;
         check_word($sformatf("table step %0d", i), steps[i].exp_data, resp);
      end

      // random traffic, half of it packed into the top lines
      for (int i = 0; i < num_random; i++)
      begin
         addr     = ($urandom % 2 == 0) ? vram_addr_w'($urandom % 256)
                                        : vram_addr_w'($urandom % vram_words);
         op       = ($urandom % 2 == 0) ? op_read : op_write;
         data     = $urandom;
         exp_data = (op == op_write) ? data : model[addr];
         host_access(op, addr, data, 1'b1, resp);
         if (op == op_write)
            model[addr] = data;
         check_word($sformatf("random access %0d", i), exp_data, resp);
      end
      check_word("response count", req_count, resp_count);

      scan_enable = 1'b1;
      check_frame("frame 1", 1'b0);
      check_frame("frame 2 stalled", 1'b1);  // starts on the wrapped pixel 0
      pix_ready   = 1'b0;
      scan_enable = 1'b0;

      // display off, touch line starts and the last word
      for (int i = 0; i < 5; i++)
      begin
         addr = (i == 4) ? vram_addr_w'(vram_words - 1) : vram_addr_w'(i * words_per_line);
         data = $urandom;
         host_access(op_write, addr, data, 1'b0, resp);
         model[addr] = data;
         check_word($sformatf("blanked write %0d", i), data, resp);
      end

      scan_enable = 1'b1;
      check_frame("frame after restart", 1'b0);
      pix_ready   = 1'b0;
      scan_enable = 1'b0;

      if (error_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/vram_assert.sv
// handshake checks on the video memory top level
// response and pixel channels hold under back-pressure, one host transfer at a time
`timescale 1ns/1ps
`default_nettype none

module vram_assert
   import vram_pkg::*;
(
   input logic                   clk_a,
   input logic                   reset,
   input logic                   req_ready,
   input logic                   resp_valid,
   input logic [vram_data_w-1:0] resp_data,
   input logic                   resp_ready,
   input logic                   scan_enable,
   input logic                   pix_valid,
   input logic                   pix_data,
   input logic                   pix_ready
);

   resp_hold: assert property (@(posedge clk_a) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
      else $error("response changed while stalled");

   // dropping scan_enable is allowed to abandon the pixel
   pix_hold: assert property (@(posedge clk_a) disable iff (reset)
      scan_enable && pix_valid && !pix_ready |=>
         !scan_enable || (pix_valid && $stable(pix_data)))
      else $error("pixel changed while stalled");

   busy_ready: assert property (@(posedge clk_a) disable iff (reset)
      resp_valid |-> !req_ready)
      else $error("request accepted while a response is pending");

endmodule

`default_nettype wire

//--- tests/vram_clkgen.sv
// testbench clock and reset
// 8 ns clk_a, reset high for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module vram_clkgen
(
   output logic clk_a,
   output logic reset
);

   initial
   begin
      clk_a = 1'b0;
      forever
         #4 clk_a = ~clk_a;
   end

   initial
   begin
      reset = 1'b1;
      repeat (2) @(posedge clk_a);
      @(negedge clk_a);  // released on a falling edge
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- verilog/vram_top.sv
// video memory top level
// host port on RAM port A, scanout engine on RAM port B
`timescale 1ns/1ps
`default_nettype none

module vram_top
   import vram_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,

   input  logic                   req_valid,
   input  host_op_t               req_op,
   input  logic [vram_addr_w-1:0] req_addr,
   input  logic [vram_data_w-1:0] req_wdata,
   output logic                   req_ready,

   output logic                   resp_valid,
   output logic [vram_data_w-1:0] resp_data,
   input  logic                   resp_ready,

   input  logic                   scan_enable,
   output logic                   pix_valid,
   output logic                   pix_data,
   output logic                   pix_line_start,
   output logic                   pix_frame_start,
   input  logic                   pix_ready
);

   logic [vram_addr_w-1:0] addr_a;
   logic [vram_data_w-1:0] wdata_a;
   logic                   wren_a;
   logic                   rden_a;
   logic [vram_data_w-1:0] q_a;

   logic [vram_addr_w-1:0] addr_b;
   logic                   rden_b;
   logic [vram_data_w-1:0] q_b;

   vram_host_port host_port_i
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_op     (req_op),
      .req_addr   (req_addr),
      .req_wdata  (req_wdata),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp_data  (resp_data),
      .resp_ready (resp_ready),
      .addr_a     (addr_a),
      .wdata_a    (wdata_a),
      .wren_a     (wren_a),
      .rden_a     (rden_a),
      .q_a        (q_a)
   );

   vram_scanout scanout_i
   (
      .clk_a           (clk_a),
      .reset           (reset),
      .scan_enable     (scan_enable),
      .addr_b          (addr_b),
      .rden_b          (rden_b),
      .q_b             (q_b),
      .pix_valid       (pix_valid),
      .pix_data        (pix_data),
      .pix_line_start  (pix_line_start),
      .pix_frame_start (pix_frame_start),
      .pix_ready       (pix_ready)
   );

   vram_dpram dpram_i
   (
      .clk_a   (clk_a),
      .reset   (reset),
      .addr_a  (addr_a),
      .wdata_a (wdata_a),
      .wren_a  (wren_a),
      .rden_a  (rden_a),
      .q_a     (q_a),
      .addr_b  (addr_b),
      .rden_b  (rden_b),
      .q_b     (q_b)
   );

endmodule

`default_nettype wire

//--- verilog/vram_scanout.sv
// raster scanout engine
// fetches words from RAM port B in address order into a two-word buffer
// and shifts them out as a one-bit pixel stream, lsb first
`timescale 1ns/1ps
`default_nettype none

module vram_scanout
   import vram_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   scan_enable,

   // RAM port B
   output logic [vram_addr_w-1:0] addr_b,
   output logic                   rden_b,
   input  logic [vram_data_w-1:0] q_b,

   // pixel channel
   output logic                   pix_valid,
   output logic                   pix_data,
   output logic                   pix_line_start,
   output logic                   pix_frame_start,
   input  logic                   pix_ready
);

   scan_state_t state;

   logic [vram_addr_w-1:0] fetch_addr;
   logic                   in_flight;  // q_b carries a fetched word

   logic [vram_data_w-1:0] buf_word [0:1];
   logic [1:0]             buf_cnt;
   logic                   rd_sel;
   logic                   wr_sel;

   logic [vram_data_w-1:0] shift_word;
   logic [pix_idx_w-1:0]   pix_idx;
   logic                   shift_valid;

   logic [word_cnt_w-1:0]  word_cnt;  // word of the line in the shifter
   logic [line_cnt_w-1:0]  line_cnt;

   logic active;
   logic slot_free;
   logic fetch;
   logic pix_take;
   logic word_done;
   logic load;
   logic word_start;

   assign active    = scan_enable & (state != scan_idle);
   // count the word in flight as taken
   assign slot_free = (buf_cnt == 2'd0) | ((buf_cnt == 2'd1) & ~in_flight);
   assign fetch     = active & slot_free;

   assign addr_b = fetch_addr;
   assign rden_b = fetch;

   assign pix_take  = shift_valid & pix_ready;
   assign word_done = pix_take & (&pix_idx);  // last pixel of the word
   assign load      = active & (buf_cnt != 2'd0) & (~shift_valid | word_done);

   assign word_start      = shift_valid & (pix_idx == '0) & (word_cnt == '0);
   assign pix_valid       = shift_valid;
   assign pix_data        = shift_word[0];
   assign pix_line_start  = word_start;
   assign pix_frame_start = word_start & (line_cnt == '0);

   // word buffer and shifter data
   always_ff @(posedge clk_a)
   begin
      if (in_flight)
         buf_word[wr_sel] <= q_b;

      if (load)
         shift_word <= buf_word[rd_sel];
      else if (pix_take)
         shift_word <= shift_word >> 1;
   end

   // dropping scan_enable abandons the frame
   always_ff @(posedge clk_a)
   begin
      if (reset || !scan_enable)
      begin
         state       <= scan_idle;
         fetch_addr  <= '0;
         in_flight   <= 1'b0;
         buf_cnt     <= 2'd0;
         rd_sel      <= 1'b0;
         wr_sel      <= 1'b0;
         pix_idx     <= '0;
         shift_valid <= 1'b0;
         word_cnt    <= '0;
         line_cnt    <= '0;
      end
      else
      begin
         case (state)
            scan_idle: state <= scan_fill;
            scan_fill: if (load) state <= scan_run;
            scan_run:  state <= scan_run;
            default:   state <= scan_idle;
         endcase

         in_flight <= fetch;
         if (fetch)
         begin
            if (fetch_addr == vram_addr_w'(vram_words - 1))
               fetch_addr <= '0;  // wrap to top of frame
            else
               fetch_addr <= fetch_addr + 1'b1;
         end

         if (in_flight)
            wr_sel <= ~wr_sel;
         if (in_flight && !load)
            buf_cnt <= buf_cnt + 2'd1;
         else if (!in_flight && load)
            buf_cnt <= buf_cnt - 2'd1;

         if (pix_take)
            pix_idx <= pix_idx + 1'b1;
         if (word_done)
            shift_valid <= 1'b0;  // underrun, refilled by load
         if (load)
         begin
            rd_sel      <= ~rd_sel;
            shift_valid <= 1'b1;
            pix_idx     <= '0;
         end

         // raster position of the shifter word
         if (word_done)
         begin
            if (word_cnt == word_cnt_w'(words_per_line - 1))
            begin
               word_cnt <= '0;
               if (line_cnt == line_cnt_w'(lines_per_frame - 1))
                  line_cnt <= '0;
               else
                  line_cnt <= line_cnt + 1'b1;
            end
            else
               word_cnt <= word_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/vram_host_port.sv
// host port adapter
// turns valid/ready requests into RAM port A cycles, one transfer at a time,
// and returns the read or written word on the response channel
`timescale 1ns/1ps
`default_nettype none

module vram_host_port
   import vram_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,

   // request channel
   input  logic                   req_valid,
   input  host_op_t               req_op,
   input  logic [vram_addr_w-1:0] req_addr,
   input  logic [vram_data_w-1:0] req_wdata,
   output logic                   req_ready,

   // response channel
   output logic                   resp_valid,
   output logic [vram_data_w-1:0] resp_data,
   input  logic                   resp_ready,

   // RAM port A
   output logic [vram_addr_w-1:0] addr_a,
   output logic [vram_data_w-1:0] wdata_a,
   output logic                   wren_a,
   output logic                   rden_a,
   input  logic [vram_data_w-1:0] q_a
);

   logic accept;     // request transfers this cycle
   logic resp_take;  // response transfers this cycle
   logic pend;       // RAM cycle issued last edge, q_a now valid

   assign accept    = req_valid & req_ready;
   assign resp_take = resp_valid & resp_ready;

   // port A follows the request only in its accept cycle
   assign addr_a  = req_addr;
   assign wdata_a = req_wdata;
   assign wren_a  = accept & (req_op == op_write);
   assign rden_a  = accept & (req_op == op_read);

   // enables stay low while busy, so q_a holds the answer
   assign resp_data = q_a;

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         pend       <= 1'b0;
         resp_valid <= 1'b0;
         req_ready  <= 1'b0;
      end
      else
      begin
         pend <= accept;

         if (pend)
            resp_valid <= 1'b1;
         else if (resp_take)
            resp_valid <= 1'b0;

         // ready again only once the response has left
         req_ready <= ~accept & ~pend & (~resp_valid | resp_take);
      end
   end

endmodule

`default_nettype wire

//--- verilog/vram_dpram.sv
// video RAM, 21504 x 32
// port A reads and writes for the host, port B is the read-only scanout side
`timescale 1ns/1ps
`default_nettype none

module vram_dpram
   import vram_pkg::*;
(
   input  logic                   clk_a,
   input  logic                   reset,

   input  logic [vram_addr_w-1:0] addr_a,
   input  logic [vram_data_w-1:0] wdata_a,
   input  logic                   wren_a,
   input  logic                   rden_a,
   output logic [vram_data_w-1:0] q_a,

   input  logic [vram_addr_w-1:0] addr_b,
   input  logic                   rden_b,
   output logic [vram_data_w-1:0] q_b
);

   logic [vram_data_w-1:0] mem [0:vram_words-1];

   // frame starts out blank
   initial
   begin
      for (int i = 0; i < vram_words; i++)
         mem[i] = '0;
   end

   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         mem[addr_a] <= wdata_a;
   end

   // port A output, a write echoes the stored word
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (wren_a)
         q_a <= wdata_a;
      else if (rden_a)
         q_a <= mem[addr_a];
   end

   // port B sees old contents on a same-word collision
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= mem[addr_b];
   end

endmodule

`default_nettype wire

//--- verilog/vram_pkg.sv
// vram package
// frame geometry, widths and the enums shared by the video memory blocks
`default_nettype none

package vram_pkg;

   // one 768 x 896 mono frame, 32 pixels per word
   localparam int vram_words      = 21504;
   localparam int vram_addr_w     = 15;
   localparam int vram_data_w     = 32;
   localparam int words_per_line  = 24;
   localparam int lines_per_frame = 896;

   // counter widths for the scanout
   localparam int word_cnt_w = $clog2(words_per_line);
   localparam int line_cnt_w = $clog2(lines_per_frame);
   localparam int pix_idx_w  = $clog2(vram_data_w);

   // host request opcode
   typedef enum logic
   {
      op_read  = 1'b0,
      op_write = 1'b1
   } host_op_t;

   // scanout fetch machine
   typedef enum logic [1:0]
   {
      scan_idle = 2'd0,  // disabled, fetch address parked at 0
      scan_fill = 2'd1,  // waiting for the first word
      scan_run  = 2'd2   // pixels streaming
   } scan_state_t;

endpackage

`default_nettype wire
